// File: source/interruptPkg.sv
// Shared types and constants for a 32-bit core with S-mode always present; no Sstc, no U-mode interrupts
`default_nettype none

package interruptPkg;

  //////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////
  localparam int xlen = 32;

  typedef logic [11:0]     csrAddr;
  typedef logic [xlen-1:0] csrData;
  // One bit per interrupt cause, indexed by cause code
  typedef logic [11:0]     irqVector;
  typedef logic [1:0]      privMode;

  // Privilege encodings (2 is reserved)
  localparam privMode privUser       = 2'd0;
  localparam privMode privSupervisor = 2'd1;
  localparam privMode privMachine    = 2'd3;

  //////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////
  localparam csrAddr mstatusAdr = 12'h300;
  localparam csrAddr midelegAdr = 12'h303;
  localparam csrAddr mieAdr     = 12'h304;
  localparam csrAddr mipAdr     = 12'h344;
  localparam csrAddr sieAdr     = 12'h104;
  localparam csrAddr sipAdr     = 12'h144;

  // Global enable bit positions in mstatus
  localparam int mstatusMieBit = 3;
  localparam int mstatusSieBit = 1;

  //////////////////////////////////////////////////
  // Write masks
  //////////////////////////////////////////////////
  // SEIP, STIP, SSIP writable through mip
  localparam irqVector mipWriteMask     = 12'h222;
  // Only SSIP through sip, further gated by mideleg
  localparam irqVector sipWriteMask     = 12'h002;
  localparam irqVector mieWriteMask     = 12'hAAA;
  localparam irqVector sieFieldMask     = 12'h222;
  localparam irqVector midelegWriteMask = 12'h222;
  localparam irqVector machineFieldMask = 12'h888;

  // Interrupt cause codes
  localparam logic [3:0] causeSsi = 4'd1;
  localparam logic [3:0] causeMsi = 4'd3;
  localparam logic [3:0] causeSti = 4'd5;
  localparam logic [3:0] causeMti = 4'd7;
  localparam logic [3:0] causeSei = 4'd9;
  localparam logic [3:0] causeMei = 4'd11;

  // Trap request arbiter states
  typedef enum logic {
    arbIdle,
    arbOffer
  } arbState;

endpackage

`default_nettype wire

// File: source/csrWriteIf.sv
// CSR write bus; at most one of mWrite and sWrite may be high in a cycle
`default_nettype none

interface csrWriteIf import interruptPkg::*; ();

  // Write issued at machine privilege
  logic   mWrite;
  // Write issued at supervisor privilege
  logic   sWrite;
  csrAddr addr;
  csrData wdata;

  // Register blocks only observe the bus
  modport sink (
    input mWrite,
    input sWrite,
    input addr,
    input wdata
  );

endinterface

`default_nettype wire

// File: source/interruptRegs.sv
// MIP/MIE storage; MEIP, MTIP and MSIP follow the input lines and cannot be written
`default_nettype none

module interruptRegs import interruptPkg::*; (
  input  logic     clk,
  input  logic     reset,
  csrWriteIf.sink  wr,
  input  logic     mExtInt,
  input  logic     sExtInt,
  input  logic     mTimerInt,
  input  logic     mSwInt,
  input  irqVector mideleg,
  output irqVector mip,
  output irqVector mie
);

  // Only SEIP, STIP, SSIP positions ever hold ones
  irqVector pendingStored;
  irqVector writeBits;
  irqVector sipMask;
  irqVector sieMask;
  logic     writeMip;
  logic     writeSip;
  logic     writeMie;
  logic     writeSie;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////
  assign writeMip = wr.mWrite & (wr.addr == mipAdr);
  assign writeMie = wr.mWrite & (wr.addr == mieAdr);
  assign writeSip = wr.sWrite & (wr.addr == sipAdr);
  assign writeSie = wr.sWrite & (wr.addr == sieAdr);

  // Interrupt fields sit in the low 12 bits
  assign writeBits = wr.wdata[11:0];

  // Supervisor view reaches only delegated bits
  assign sipMask = sipWriteMask & mideleg;
  assign sieMask = sieFieldMask & mideleg;

  //////////////////////////////////////////////////
  // Pending and enable registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      pendingStored <= '0;
    end else if (writeMip) begin
      pendingStored <= writeBits & mipWriteMask;
    end else if (writeSip) begin
      // Merge SSIP, keep everything else
      pendingStored <= (writeBits & sipMask) | (pendingStored & ~sipMask);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mie <= '0;
    end else if (writeMie) begin
      mie <= writeBits & mieWriteMask;
    end else if (writeSie) begin
      // Machine fields and undelegated S fields hold
      mie <= (writeBits & sieMask) | (mie & ~sieMask);
    end
  end

  // Pending vector seen by readers and the arbiter
  // SEIP is the external line or the software-set bit
  assign mip = {mExtInt,   1'b0, sExtInt | pendingStored[9], 1'b0,
                mTimerInt, 1'b0, pendingStored[5],           1'b0,
                mSwInt,    1'b0, pendingStored[1],           1'b0};

endmodule

`default_nettype wire

// File: source/trapControlRegs.sv
// MIDELEG and mstatus MIE/SIE only; sstatus writes arrive on the mstatus address with sWrite
`default_nettype none

module trapControlRegs import interruptPkg::*; (
  input  logic     clk,
  input  logic     reset,
  csrWriteIf.sink  wr,
  output irqVector mideleg,
  output logic     mstatusMie,
  output logic     mstatusSie
);

  logic writeMideleg;
  logic writeMstatus;
  logic writeSstatus;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////
  assign writeMideleg = wr.mWrite & (wr.addr == midelegAdr);
  assign writeMstatus = wr.mWrite & (wr.addr == mstatusAdr);
  // Supervisor view of the same status register
  assign writeSstatus = wr.sWrite & (wr.addr == mstatusAdr);

  // Delegation only for S-level causes
  always_ff @(posedge clk) begin
    if (reset) begin
      mideleg <= '0;
    end else if (writeMideleg) begin
      mideleg <= wr.wdata[11:0] & midelegWriteMask;
    end
  end

  //////////////////////////////////////////////////
  // Global interrupt enables
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusMie <= 1'b0;
    end else if (writeMstatus) begin
      mstatusMie <= wr.wdata[mstatusMieBit];
    end
  end

  // SIE is reachable from both views
  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusSie <= 1'b0;
    end else if (writeMstatus | writeSstatus) begin
      mstatusSie <= wr.wdata[mstatusSieBit];
    end
  end

endmodule

`default_nettype wire

// File: source/interruptArbiter.sv
// Offer is held until irqReady even if pending lines change; one idle cycle follows each handshake
`default_nettype none

module interruptArbiter import interruptPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  privMode    priv,
  input  irqVector   mip,
  input  irqVector   mie,
  input  irqVector   mideleg,
  input  logic       mstatusMie,
  input  logic       mstatusSie,
  output logic       irqValid,
  output logic [3:0] irqCause,
  output logic       irqToSupervisor,
  input  logic       irqReady
);

  arbState    state;
  irqVector   candidates;
  irqVector   takeable;
  logic       mLevelOpen;
  logic       sLevelOpen;
  logic       anyTakeable;
  logic [3:0] bestCause;

  //////////////////////////////////////////////////
  // Takeable interrupts
  //////////////////////////////////////////////////
  assign candidates = mip & mie;

  // Machine-level causes open below M or with MIE set
  assign mLevelOpen = (priv != privMachine) | mstatusMie;
  // Delegated causes never interrupt M mode
  assign sLevelOpen = (priv == privUser) | ((priv == privSupervisor) & mstatusSie);

  assign takeable = candidates & ((~mideleg & {12{mLevelOpen}}) |
                                  (mideleg & {12{sLevelOpen}}));
  assign anyTakeable = |takeable;

  // Fixed priority MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    if (takeable[causeMei]) begin
      bestCause = causeMei;
    end else if (takeable[causeMsi]) begin
      bestCause = causeMsi;
    end else if (takeable[causeMti]) begin
      bestCause = causeMti;
    end else if (takeable[causeSei]) begin
      bestCause = causeSei;
    end else if (takeable[causeSsi]) begin
      bestCause = causeSsi;
    end else begin
      bestCause = causeSti;
    end
  end

  //////////////////////////////////////////////////
  // Offer FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arbIdle;
    end else begin
      case (state)
        arbIdle:  if (anyTakeable) state <= arbOffer;
        arbOffer: if (irqReady) state <= arbIdle;
        default:  state <= arbIdle;
      endcase
    end
  end

  // Latch the choice on entry, hold through back-pressure
  always_ff @(posedge clk) begin
    if ((state == arbIdle) && anyTakeable) begin
      irqCause        <= bestCause;
      irqToSupervisor <= mideleg[bestCause];
    end
  end

  assign irqValid = (state == arbOffer);

endmodule

`default_nettype wire

// File: source/csrReadMux.sv
// Combinational read of the interrupt CSRs only; unknown addresses return zero
`default_nettype none

module csrReadMux import interruptPkg::*; (
  input  csrAddr   readAddr,
  input  irqVector mip,
  input  irqVector mie,
  input  irqVector mideleg,
  input  logic     mstatusMie,
  input  logic     mstatusSie,
  output csrData   readData
);

  //////////////////////////////////////////////////
  // Read select
  //////////////////////////////////////////////////
  always_comb begin
    // Upper bits stay zero for every register here
    readData = '0;
    case (readAddr)
      mipAdr: begin
        readData[11:0] = mip;
      end
      mieAdr: begin
        readData[11:0] = mie;
      end
      // Supervisor views see only delegated bits
      sipAdr: begin
        readData[11:0] = mip & mideleg;
      end
      sieAdr: begin
        readData[11:0] = mie & mideleg;
      end
      midelegAdr: begin
        readData[11:0] = mideleg;
      end
      mstatusAdr: begin
        readData[mstatusMieBit] = mstatusMie;
        readData[mstatusSieBit] = mstatusSie;
      end
      default: begin
        readData = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/interruptTop.sv
// Interrupt CSR block top; caller keeps csrMWrite and csrSWrite mutually exclusive
`default_nettype none

module interruptTop import interruptPkg::*; (
  input  logic                clk,
  input  logic                reset,
  // CSR write port from the pipeline
  input  logic                csrMWrite,
  input  logic                csrSWrite,
  input  interruptPkg::csrAddr csrAddr,
  input  csrData              csrWriteData,
  // CSR read port
  input  interruptPkg::csrAddr readAddr,
  output csrData              readData,
  // Interrupt lines
  input  logic                mExtInt,
  input  logic                sExtInt,
  input  logic                mTimerInt,
  input  logic                mSwInt,
  // Trap request
  input  privMode             priv,
  output logic                irqValid,
  output logic [3:0]          irqCause,
  output logic                irqToSupervisor,
  input  logic                irqReady
);

  irqVector mip;
  irqVector mie;
  irqVector mideleg;
  logic     mstatusMie;
  logic     mstatusSie;

  //////////////////////////////////////////////////
  // Write bus
  //////////////////////////////////////////////////
  csrWriteIf wrBus ();

  assign wrBus.mWrite = csrMWrite;
  assign wrBus.sWrite = csrSWrite;
  assign wrBus.addr   = csrAddr;
  assign wrBus.wdata  = csrWriteData;

  //////////////////////////////////////////////////
  // Register blocks
  //////////////////////////////////////////////////
  interruptRegs regs (
    .clk       (clk),
    .reset     (reset),
    .wr        (wrBus.sink),
    .mExtInt   (mExtInt),
    .sExtInt   (sExtInt),
    .mTimerInt (mTimerInt),
    .mSwInt    (mSwInt),
    .mideleg   (mideleg),
    .mip       (mip),
    .mie       (mie)
  );

  trapControlRegs ctrl (
    .clk        (clk),
    .reset      (reset),
    .wr         (wrBus.sink),
    .mideleg    (mideleg),
    .mstatusMie (mstatusMie),
    .mstatusSie (mstatusSie)
  );

  // Selection and trap handshake
  interruptArbiter arb (
    .clk             (clk),
    .reset           (reset),
    .priv            (priv),
    .mip             (mip),
    .mie             (mie),
    .mideleg         (mideleg),
    .mstatusMie      (mstatusMie),
    .mstatusSie      (mstatusSie),
    .irqValid        (irqValid),
    .irqCause        (irqCause),
    .irqToSupervisor (irqToSupervisor),
    .irqReady        (irqReady)
  );

  csrReadMux readMux (
    .readAddr   (readAddr),
    .mip        (mip),
    .mie        (mie),
    .mideleg    (mideleg),
    .mstatusMie (mstatusMie),
    .mstatusSie (mstatusSie),
    .readData   (readData)
  );

endmodule

`default_nettype wire

// File: tb/interruptTb.sv
// Directed test of the interrupt CSR block; assumes S-mode present, no Sstc, inputs change on negedge
`default_nettype none

module interruptTb import interruptPkg::*; ();

  // Cycles allowed for any single wait on irqValid
  localparam int waitLimit = 40;

  logic       clk;
  logic       reset;
  logic       csrMWrite;
  logic       csrSWrite;
  csrAddr     wrAddr;
  csrData     wrData;
  csrAddr     readAddr;
  csrData     readData;
  logic       mExtInt;
  logic       sExtInt;
  logic       mTimerInt;
  logic       mSwInt;
  privMode    priv;
  logic       irqValid;
  logic [3:0] irqCause;
  logic       irqToSupervisor;
  logic       irqReady;

  // Reference copy of the CSR state
  irqVector refPend;
  irqVector refMie;
  irqVector refDeleg;
  logic     refMstatusMie;
  logic     refMstatusSie;

  int errorCount;
  int checkCount;
  int seed;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  interruptTop UUT (
    .clk             (clk),
    .reset           (reset),
    .csrMWrite       (csrMWrite),
    .csrSWrite       (csrSWrite),
    .csrAddr         (wrAddr),
    .csrWriteData    (wrData),
    .readAddr        (readAddr),
    .readData        (readData),
    .mExtInt         (mExtInt),
    .sExtInt         (sExtInt),
    .mTimerInt       (mTimerInt),
    .mSwInt          (mSwInt),
    .priv            (priv),
    .irqValid        (irqValid),
    .irqCause        (irqCause),
    .irqToSupervisor (irqToSupervisor),
    .irqReady        (irqReady)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Machine lines on 11, 7, 3; SEIP is line OR software bit
  function automatic irqVector refMip();
    irqVector v;
    v = refPend;
    v[11] = mExtInt;
    v[9]  = refPend[9] | sExtInt;
    v[7]  = mTimerInt;
    v[3]  = mSwInt;
    return v;
  endfunction

  function automatic csrData refRead(csrAddr a);
    csrData d;
    d = '0;
    case (a)
      mipAdr:     d[11:0] = refMip();
      mieAdr:     d[11:0] = refMie;
      sipAdr:     d[11:0] = refMip() & refDeleg;
      sieAdr:     d[11:0] = refMie & refDeleg;
      midelegAdr: d[11:0] = refDeleg;
      mstatusAdr: begin
        d[3] = refMstatusMie;
        d[1] = refMstatusSie;
      end
      default:    d = '0;
    endcase
    return d;
  endfunction

  function automatic void applyWrite(logic machine, csrAddr a, csrData d);
    irqVector m;
    m = '0;
    if (machine) begin
      case (a)
        mipAdr:     refPend = d[11:0] & mipWriteMask;
        mieAdr:     refMie = d[11:0] & mieWriteMask;
        midelegAdr: refDeleg = d[11:0] & midelegWriteMask;
        mstatusAdr: begin
          refMstatusMie = d[3];
          refMstatusSie = d[1];
        end
        default:    ;
      endcase
    end else begin
      case (a)
        // Supervisor side reaches delegated S fields only
        sipAdr: begin
          m = sipWriteMask & refDeleg;
          refPend = (d[11:0] & m) | (refPend & ~m);
        end
        sieAdr: begin
          m = sieFieldMask & refDeleg;
          refMie = (d[11:0] & m) | (refMie & ~m);
        end
        mstatusAdr: refMstatusSie = d[1];
        default:    ;
      endcase
    end
  endfunction

  //////////////////////////////////////////////////
  // Bus and handshake helpers
  //////////////////////////////////////////////////
  // One-cycle write strobe, starts and ends on negedge
  task automatic csrWrite(logic machine, csrAddr a, csrData d);
    csrMWrite = machine;
    csrSWrite = ~machine;
    wrAddr    = a;
    wrData    = d;
    @(negedge clk);
    csrMWrite = 1'b0;
    csrSWrite = 1'b0;
    applyWrite(machine, a, d);
  endtask

  // Sampled mid low phase, same cycle as address
  task automatic checkRead(csrAddr a);
    csrData expected;
    readAddr = a;
    #2;
    expected = refRead(a);
    checkCount++;
    assert (readData == expected) else begin
      errorCount++;
      $display("FAILED %0t: CSR %h read %h, expected %h", $time, a, readData, expected);
    end
    @(negedge clk);
  endtask

  task automatic waitValid();
    int cycles;
    cycles = 0;
    while (!irqValid && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!irqValid) begin
      errorCount++;
      $display("Timeout at %0t: arbiter stayed in arbIdle for %0d cycles", $time, waitLimit);
    end
  endtask

  task automatic checkOffer(logic [3:0] cause, logic toSup);
    checkCount++;
    assert (irqValid && irqCause == cause && irqToSupervisor == toSup) else begin
      errorCount++;
      $display("FAILED %0t: offer valid %b cause %0d toS %b, expected cause %0d toS %b",
               $time, irqValid, irqCause, irqToSupervisor, cause, toSup);
    end
  endtask

  task automatic checkIdle();
    checkCount++;
    assert (!irqValid) else begin
      errorCount++;
      $display("FAILED %0t: arbOffer with cause %0d, expected arbIdle", $time, irqCause);
    end
  endtask

  // Wait, check, then one cycle of irqReady
  task automatic takeOffer(logic [3:0] cause, logic toSup);
    waitValid();
    checkOffer(cause, toSup);
    irqReady = 1'b1;
    @(negedge clk);
    irqReady = 1'b0;
  endtask

  task automatic clearRegs();
    csrWrite(1'b1, mipAdr, 32'h0);
    csrWrite(1'b1, mieAdr, 32'h0);
    csrWrite(1'b1, midelegAdr, 32'h0);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic testReset();
    checkRead(mipAdr);
    checkRead(mieAdr);
    checkRead(sipAdr);
    checkRead(sieAdr);
    checkRead(midelegAdr);
    checkRead(mstatusAdr);
    checkIdle();
  endtask

  task automatic testMachineWrites();
    // M mode with MIE clear, so nothing can be offered
    for (int i = 0; i < 4; i++) begin
      csrWrite(1'b1, mipAdr, $random(seed));
      csrWrite(1'b1, mieAdr, $random(seed));
      csrWrite(1'b1, midelegAdr, $random(seed));
      checkRead(mipAdr);
      checkRead(mieAdr);
      checkRead(midelegAdr);
      checkRead(sipAdr);
    end
    // Lines are visible without a clock edge
    mExtInt   = 1'b1;
    sExtInt   = 1'b1;
    mTimerInt = 1'b1;
    mSwInt    = 1'b1;
    checkRead(mipAdr);
    checkRead(sipAdr);
    mExtInt   = 1'b0;
    sExtInt   = 1'b0;
    mTimerInt = 1'b0;
    mSwInt    = 1'b0;
    clearRegs();
  endtask

  task automatic testSupervisorWrites();
    csrWrite(1'b1, midelegAdr, 32'h202);
    csrWrite(1'b1, mieAdr, 32'hFFF);
    // Clears SEIE and SSIE only
    csrWrite(1'b0, sieAdr, 32'h0);
    checkRead(mieAdr);
    checkRead(sieAdr);
    csrWrite(1'b0, sipAdr, 32'hFFF);
    checkRead(mipAdr);
    checkRead(sipAdr);
    // SSI undelegated, so SSIP must survive
    csrWrite(1'b1, midelegAdr, 32'h200);
    csrWrite(1'b0, sipAdr, 32'h0);
    csrWrite(1'b0, sieAdr, 32'hFFF);
    checkRead(mipAdr);
    checkRead(mieAdr);
    checkRead(sieAdr);
    for (int i = 0; i < 3; i++) begin
      csrWrite(1'b1, midelegAdr, $random(seed));
      csrWrite(1'b0, sieAdr, $random(seed));
      csrWrite(1'b0, sipAdr, $random(seed));
      checkRead(mieAdr);
      checkRead(sieAdr);
      checkRead(sipAdr);
    end
    // sstatus view touches SIE only
    csrWrite(1'b0, mstatusAdr, 32'hA);
    checkRead(mstatusAdr);
    csrWrite(1'b1, mstatusAdr, 32'h0);
    clearRegs();
  endtask

  task automatic testPriority();
    csrWrite(1'b1, mieAdr, 32'hAAA);
    csrWrite(1'b1, mstatusAdr, 32'h8);
    mTimerInt = 1'b1;
    mSwInt    = 1'b1;
    mExtInt   = 1'b1;
    takeOffer(causeMei, 1'b0);
    mExtInt = 1'b0;
    takeOffer(causeMsi, 1'b0);
    mSwInt = 1'b0;
    takeOffer(causeMti, 1'b0);
    mTimerInt = 1'b0;
    repeat (3) @(negedge clk);
    checkIdle();
  endtask

  task automatic testDelegation();
    csrWrite(1'b1, midelegAdr, 32'h020);
    csrWrite(1'b1, mipAdr, 32'h020);
    // Delegated STI is masked in M mode
    repeat (4) @(negedge clk);
    checkIdle();
    csrWrite(1'b0, mstatusAdr, 32'h2);
    priv = privSupervisor;
    takeOffer(causeSti, 1'b1);
    priv = privMachine;
    repeat (2) @(negedge clk);
    checkIdle();
    priv = privUser;
    takeOffer(causeSti, 1'b1);
    priv = privMachine;
    csrWrite(1'b1, mipAdr, 32'h0);
    csrWrite(1'b1, midelegAdr, 32'h0);
  endtask

  task automatic testBackPressure();
    mTimerInt = 1'b1;
    waitValid();
    checkOffer(causeMti, 1'b0);
    // Higher cause arrives, original goes away
    mExtInt   = 1'b1;
    mTimerInt = 1'b0;
    repeat (3) begin
      @(negedge clk);
      checkOffer(causeMti, 1'b0);
    end
    irqReady = 1'b1;
    @(negedge clk);
    irqReady = 1'b0;
    // Exactly one idle cycle before the next offer
    checkIdle();
    @(negedge clk);
    checkOffer(causeMei, 1'b0);
    irqReady = 1'b1;
    @(negedge clk);
    irqReady = 1'b0;
    mExtInt  = 1'b0;
    repeat (2) @(negedge clk);
    checkIdle();
  endtask

  initial begin
    seed          = 28;
    errorCount    = 0;
    checkCount    = 0;
    reset         = 1'b1;
    csrMWrite     = 1'b0;
    csrSWrite     = 1'b0;
    wrAddr        = '0;
    wrData        = '0;
    readAddr      = '0;
    mExtInt       = 1'b0;
    sExtInt       = 1'b0;
    mTimerInt     = 1'b0;
    mSwInt        = 1'b0;
    priv          = privMachine;
    irqReady      = 1'b0;
    refPend       = '0;
    refMie        = '0;
    refDeleg      = '0;
    refMstatusMie = 1'b0;
    refMstatusSie = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testReset();
    testMachineWrites();
    testSupervisorWrites();
    testPriority();
    testDelegation();
    testBackPressure();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/interruptPkg.sv
source/csrWriteIf.sv
source/interruptRegs.sv
source/trapControlRegs.sv
source/interruptArbiter.sv
source/csrReadMux.sv
source/interruptTop.sv
tb/interruptTb.sv

// File: Makefile
# Verilator build and run of the interrupt CSR testbench
TOP := interruptTb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
